/* bench/bp_model.svh */
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

localparam int ENTRIES  = 1 << INDEX_BITS;
localparam int TAG_BITS = bp_pkg::PC_BITS - INDEX_BITS - 2;

logic                m_valid   [ENTRIES];
logic [TAG_BITS-1:0] m_tag     [ENTRIES];
bp_pkg::counter_t    m_counter [ENTRIES];
bp_pkg::pc_t         m_target  [ENTRIES];

int error_count = 0;
int check_count = 0;

function automatic int slot(input bp_pkg::pc_t pc);
  return int'(pc[INDEX_BITS+1:2]);  // word index
endfunction

function automatic logic [TAG_BITS-1:0] tag_bits(input bp_pkg::pc_t pc);
  return pc[bp_pkg::PC_BITS-1:INDEX_BITS+2];
endfunction

function automatic logic model_hit(input bp_pkg::pc_t pc);
  return m_valid[slot(pc)] && (m_tag[slot(pc)] == tag_bits(pc));
endfunction

function automatic bp_pkg::prediction_t pred_of(input logic taken, input bp_pkg::pc_t target);
  bp_pkg::prediction_t p;
  p.taken  = taken;
  p.target = target;
  return p;
endfunction

function automatic bp_pkg::redirect_t redir_of(input logic flush, input bp_pkg::pc_t pc);
  bp_pkg::redirect_t r;
  r.flush_d = flush;
  r.flush_e = flush;
  r.pc      = pc;
  return r;
endfunction

function automatic bp_pkg::prediction_t expect_prediction(input bp_pkg::decode_req_t req);
  if (req.valid && (req.opcode == bp_pkg::OP_BRANCH) && model_hit(req.pc)
      && (m_counter[slot(req.pc)] >= 2'd2)) begin
    return pred_of(1'b1, m_target[slot(req.pc)]);
  end
  return pred_of(1'b0, req.pc + 32'd4);  // fall through
endfunction

function automatic bp_pkg::redirect_t expect_redirect(input bp_pkg::resolve_req_t req);
  logic wrong;
  wrong = (req.pred.taken != req.actual_taken)
          || (req.pred.taken && req.actual_taken && (req.pred.target != req.actual_target));
  return redir_of(req.valid && wrong, req.actual_taken ? req.actual_target : req.pc + 32'd4);
endfunction

task automatic model_reset();
  for (int i = 0; i < ENTRIES; i++) begin
    m_valid[i] = 1'b0;
  end
endtask

// target follows the E-stage adder on every write
task automatic model_update(input bp_pkg::resolve_req_t req);
  int i;
  i = slot(req.pc);
  if (model_hit(req.pc)) begin
    if (req.actual_taken && (m_counter[i] != 2'd3)) begin
      m_counter[i] = m_counter[i] + 2'd1;
    end else if (!req.actual_taken && (m_counter[i] != 2'd0)) begin
      m_counter[i] = m_counter[i] - 2'd1;
    end
  end else begin
    m_valid[i]   = 1'b1;
    m_tag[i]     = tag_bits(req.pc);
    m_counter[i] = req.actual_taken ? 2'd2 : 2'd1;  // weak allocation
  end
  m_target[i] = req.actual_target;
endtask

task automatic check_prediction(input bp_pkg::prediction_t exp, input bp_pkg::prediction_t act,
                                input string what);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("[FAIL] %0t: %s prediction taken=%b target=%h, expected taken=%b target=%h",
             $time, what, act.taken, act.target, exp.taken, exp.target);
  end
endtask

task automatic check_redirect(input bp_pkg::redirect_t exp, input bp_pkg::redirect_t act,
                              input string what);
  check_count++;
  if ((act.flush_d !== exp.flush_d) || (act.flush_e !== exp.flush_e)
      || (exp.flush_d && (act.pc !== exp.pc))) begin  // pc only matters with a flush
    error_count++;
    $display("[FAIL] %0t: %s redirect flush=%b/%b pc=%h, expected flush=%b pc=%h",
             $time, what, act.flush_d, act.flush_e, act.pc, exp.flush_d, exp.pc);
  end
endtask

`endif

/* bench/tb_branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;

  localparam int INDEX_BITS      = 4;  // 16 entries so aliases come quickly
  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 2;
  localparam int DIRECTED_CYCLES = 40;
  localparam int RANDOM_CYCLES   = 300;
  localparam int STIM_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;

  localparam bp_pkg::opcode_t      OP_LOAD    = 7'b0000011;
  localparam bp_pkg::decode_req_t  NO_DECODE  = '0;
  localparam bp_pkg::resolve_req_t NO_RESOLVE = '0;
  localparam bp_pkg::pc_t PC_A   = 32'h0000_1000;
  localparam bp_pkg::pc_t TGT_A  = 32'h0000_0f00;
  localparam bp_pkg::pc_t PC_C   = 32'h0000_2010;
  localparam bp_pkg::pc_t TGT_C  = 32'h0000_2400;
  localparam bp_pkg::pc_t TGT_C2 = 32'h0000_2800;
  localparam bp_pkg::pc_t PC_D   = PC_C + (32'd1 << (INDEX_BITS + 2));  // aliases PC_C
  localparam bp_pkg::pc_t TGT_D  = 32'h0000_3000;

  logic                 clk;
  logic                 rst_n;
  bp_pkg::decode_req_t  decode_req;
  bp_pkg::prediction_t  prediction;
  bp_pkg::resolve_req_t resolve_req;
  bp_pkg::redirect_t    redirect;

  `include "bp_model.svh"

  branch_predictor #(
    .INDEX_BITS (INDEX_BITS)
  ) u_branch_predictor (
    .clk         (clk),
    .rst_n       (rst_n),
    .decode_req  (decode_req),
    .prediction  (prediction),
    .resolve_req (resolve_req),
    .redirect    (redirect)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((STIM_CYCLES + 20) * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d clock cycles", STIM_CYCLES + 20);
    $display("ERRORS FOUND");
    $finish;
  end

  // compare every cycle before the model takes the edge
  initial begin
    forever begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      if (rst_n) begin
        check_prediction(expect_prediction(decode_req), prediction, "model");
        check_redirect(expect_redirect(resolve_req), redirect, "model");
      end
      @(posedge clk);
      if (!rst_n) begin
        model_reset();
      end else if (resolve_req.valid) begin
        model_update(resolve_req);
      end
    end
  end

  function automatic bp_pkg::decode_req_t lookup_of(input logic valid, input bp_pkg::pc_t pc,
                                                    input bp_pkg::opcode_t op);
    bp_pkg::decode_req_t d;
    d.valid  = valid;
    d.pc     = pc;
    d.opcode = op;
    return d;
  endfunction

  function automatic bp_pkg::resolve_req_t resolve_of(input logic valid, input bp_pkg::pc_t pc,
      input bp_pkg::prediction_t pred, input logic taken, input bp_pkg::pc_t target);
    bp_pkg::resolve_req_t r;
    r.valid         = valid;
    r.pc            = pc;
    r.pred          = pred;
    r.actual_taken  = taken;
    r.actual_target = target;
    return r;
  endfunction

  task automatic probe(input bp_pkg::decode_req_t d, input bp_pkg::prediction_t exp,
                       input string what);
    @(negedge clk);
    decode_req  = d;
    resolve_req = NO_RESOLVE;
    #(CLK_PERIOD / 4 + 5);
    check_prediction(exp, prediction, what);
  endtask

  // lookup and resolve in one cycle with the current table prediction
  task automatic resolve_branch(input bp_pkg::pc_t pc, input logic taken,
                                input bp_pkg::pc_t target);
    bp_pkg::decode_req_t d;
    @(negedge clk);
    d           = lookup_of(1'b1, pc, bp_pkg::OP_BRANCH);
    decode_req  = d;
    resolve_req = resolve_of(1'b1, pc, expect_prediction(d), taken, target);
  endtask

  task automatic redirect_case(input bp_pkg::pc_t pc, input bp_pkg::prediction_t pred,
      input logic taken, input bp_pkg::pc_t target, input bp_pkg::redirect_t exp,
      input string what);
    @(negedge clk);
    decode_req  = NO_DECODE;
    resolve_req = resolve_of(1'b1, pc, pred, taken, target);
    #(CLK_PERIOD / 4 + 5);
    check_redirect(exp, redirect, what);
  endtask

  task automatic random_mix();
    bp_pkg::pc_t         pc_set [6];
    bp_pkg::pc_t         targets [6];
    bp_pkg::prediction_t p;
    int                  k;
    int                  j;
    pc_set = '{32'h400, 32'h404, 32'h440, 32'h408, 32'h1408, 32'h480};  // aliases on 0 and 2
    for (int i = 0; i < 6; i++) begin
      targets[i] = 32'h800 + 32'(i * 16);
    end
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      @(negedge clk);
      k = int'($urandom_range(0, 5));
      j = int'($urandom_range(0, 5));
      decode_req = lookup_of($urandom_range(0, 7) != 0, pc_set[k],
                             ($urandom_range(0, 3) != 0) ? bp_pkg::OP_BRANCH : OP_LOAD);
      if ($urandom_range(0, 7) == 0) begin
        targets[j] = $urandom & 32'hffff_fffc;  // moved target
      end
      p = expect_prediction(lookup_of(1'b1, pc_set[j], bp_pkg::OP_BRANCH));
      if ($urandom_range(0, 3) == 0) begin
        p.taken = ~p.taken;
      end
      resolve_req = resolve_of($urandom_range(0, 3) != 0, pc_set[j], p,
                               $urandom_range(0, 1) == 1, targets[j]);
    end
  endtask

  initial begin
    bp_pkg::pc_t pc;
    void'($urandom(6));
    rst_n       = 1'b0;
    decode_req  = NO_DECODE;
    resolve_req = NO_RESOLVE;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < 8; i++) begin
      pc = $urandom & 32'h0000_fffc;
      probe(lookup_of(1'b1, pc, bp_pkg::OP_BRANCH), pred_of(1'b0, pc + 32'd4), "after reset");
    end

    resolve_branch(PC_A, 1'b1, TGT_A);
    probe(lookup_of(1'b1, PC_A, bp_pkg::OP_BRANCH), pred_of(1'b1, TGT_A), "weak taken");
    resolve_branch(PC_A, 1'b1, TGT_A);
    resolve_branch(PC_A, 1'b1, TGT_A);  // saturates at 3
    probe(lookup_of(1'b1, PC_A, bp_pkg::OP_BRANCH), pred_of(1'b1, TGT_A), "strong taken");
    resolve_branch(PC_A, 1'b0, TGT_A);
    probe(lookup_of(1'b1, PC_A, bp_pkg::OP_BRANCH), pred_of(1'b1, TGT_A), "one not taken");
    resolve_branch(PC_A, 1'b0, TGT_A);
    probe(lookup_of(1'b1, PC_A, bp_pkg::OP_BRANCH), pred_of(1'b0, PC_A + 32'd4),
          "two not taken");

    redirect_case(PC_A, pred_of(1'b1, TGT_A), 1'b0, TGT_A, redir_of(1'b1, PC_A + 32'd4),
                  "taken, went not taken");
    redirect_case(PC_A, pred_of(1'b0, PC_A + 32'd4), 1'b1, TGT_A, redir_of(1'b1, TGT_A),
                  "not taken, went taken");
    redirect_case(PC_A, pred_of(1'b0, PC_A + 32'd4), 1'b0, TGT_A, redir_of(1'b0, PC_A + 32'd4),
                  "correct prediction");

    resolve_branch(PC_C, 1'b1, TGT_C);
    resolve_branch(PC_C, 1'b1, TGT_C);
    redirect_case(PC_C, pred_of(1'b1, TGT_C), 1'b1, TGT_C2, redir_of(1'b1, TGT_C2),
                  "changed target");
    probe(lookup_of(1'b1, PC_C, bp_pkg::OP_BRANCH), pred_of(1'b1, TGT_C2), "learned target");

    probe(lookup_of(1'b1, PC_C, OP_LOAD), pred_of(1'b0, PC_C + 32'd4), "non-branch opcode");
    probe(lookup_of(1'b0, PC_C, bp_pkg::OP_BRANCH), pred_of(1'b0, PC_C + 32'd4),
          "invalid decode");
    probe(lookup_of(1'b1, PC_D, bp_pkg::OP_BRANCH), pred_of(1'b0, PC_D + 32'd4), "tag alias");
    resolve_branch(PC_D, 1'b0, TGT_D);  // evicts PC_C
    probe(lookup_of(1'b1, PC_C, bp_pkg::OP_BRANCH), pred_of(1'b0, PC_C + 32'd4), "evicted");

    random_mix();

    @(negedge clk);
    decode_req  = NO_DECODE;
    resolve_req = NO_RESOLVE;
    @(posedge clk);
    #1;
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* branch_predictor.f */
+incdir+bench
src/bp_pkg.sv
src/bp_table.sv
src/bp_lookup.sv
src/bp_resolve.sv
src/branch_predictor.sv
bench/tb_branch_predictor.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and decide on the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -f branch_predictor.f --top-module tb_branch_predictor \
  -Mdir obj_dir > sim.log 2>&1 \
  && ./obj_dir/Vtb_branch_predictor >> sim.log 2>&1 \
  || echo "build or simulation returned an error" >> sim.log

cat sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

/* src/bp_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_lookup #(
  parameter int INDEX_BITS = 8
) (
  input  bp_pkg::decode_req_t req,
  output bp_pkg::pc_t         tbl_pc,
  input  logic                tbl_hit,
  input  bp_pkg::counter_t    tbl_counter,
  input  bp_pkg::pc_t         tbl_target,
  output bp_pkg::prediction_t prediction
);

  logic        is_branch;
  logic        counter_taken;
  logic        predict_taken;
  bp_pkg::pc_t seq_pc;

  // table needs at least one tag bit above the index
  if (INDEX_BITS < 1 || INDEX_BITS > bp_pkg::PC_BITS - 3) begin : g_index_range
    $error("bp_lookup: INDEX_BITS %0d out of range", INDEX_BITS);
  end

  assign tbl_pc = req.pc;
  assign seq_pc = req.pc + bp_pkg::PC_STEP;

  assign is_branch     = req.valid && (req.opcode == bp_pkg::OP_BRANCH);
  assign counter_taken = (tbl_counter >= bp_pkg::COUNTER_WEAK_T);  // weak or strong taken

  // a miss always falls through, whatever the stale counter says
  assign predict_taken = is_branch && tbl_hit && counter_taken;

  always_comb begin
    prediction.taken = predict_taken;
    if (predict_taken) begin
      prediction.target = tbl_target;
    end else begin
      prediction.target = seq_pc;  // sequential fetch
    end
  end

  // no clock here, so checked combinationally
  always_comb begin
    if (prediction.taken) begin
      a_taken_is_branch: assert (req.valid && (req.opcode == bp_pkg::OP_BRANCH))
        else $error("bp_lookup: taken prediction for opcode %b at pc %h",
                    req.opcode, req.pc);
    end
  end

endmodule

`default_nettype wire

/* src/bp_pkg.sv */
`default_nettype none

package bp_pkg;

  localparam int PC_BITS      = 32;
  localparam int OPCODE_BITS  = 7;
  localparam int COUNTER_BITS = 2;

  typedef logic [PC_BITS-1:0]      pc_t;
  typedef logic [OPCODE_BITS-1:0]  opcode_t;
  typedef logic [COUNTER_BITS-1:0] counter_t;

  localparam pc_t PC_STEP = 32'd4;  // rv32i, no compressed

  localparam opcode_t OP_BRANCH = 7'b1100011;  // beq/bne/blt/bge/bltu/bgeu

  // two upper values predict taken
  localparam counter_t COUNTER_STRONG_NT = 2'd0;
  localparam counter_t COUNTER_WEAK_NT   = 2'd1;
  localparam counter_t COUNTER_WEAK_T    = 2'd2;
  localparam counter_t COUNTER_STRONG_T  = 2'd3;

  typedef struct packed {
    logic    valid;
    pc_t     pc;
    opcode_t opcode;
  } decode_req_t;

  typedef struct packed {
    logic taken;
    pc_t  target;
  } prediction_t;  // rides D to E with the branch

  typedef struct packed {
    logic        valid;
    pc_t         pc;
    prediction_t pred;
    logic        actual_taken;  // ZeroE & PCSrcE
    pc_t         actual_target;
  } resolve_req_t;

  typedef struct packed {
    logic flush_d;
    logic flush_e;
    pc_t  pc;
  } redirect_t;

  typedef struct packed {
    logic     en;
    pc_t      pc;
    counter_t counter;
    pc_t      target;
  } table_wr_t;

endpackage

`default_nettype wire

/* src/bp_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_resolve #(
  parameter int INDEX_BITS = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  bp_pkg::resolve_req_t req,
  output bp_pkg::pc_t          tbl_pc,
  input  logic                 tbl_hit,
  input  bp_pkg::counter_t     tbl_counter,
  output bp_pkg::redirect_t    redirect,
  output bp_pkg::table_wr_t    table_wr
);

  logic             dir_wrong;
  logic             target_wrong;
  logic             mispredict;
  bp_pkg::pc_t      seq_pc;
  bp_pkg::counter_t next_counter;

  if (INDEX_BITS < 1 || INDEX_BITS > bp_pkg::PC_BITS - 3) begin : g_index_range
    $error("bp_resolve: INDEX_BITS %0d out of range", INDEX_BITS);
  end

  assign tbl_pc = req.pc;  // second read port, same entry as the write
  assign seq_pc = req.pc + bp_pkg::PC_STEP;

  assign dir_wrong    = (req.pred.taken != req.actual_taken);
  assign target_wrong = req.pred.taken && req.actual_taken
                        && (req.pred.target != req.actual_target);
  assign mispredict   = req.valid && (dir_wrong || target_wrong);

  always_comb begin
    redirect.flush_d = mispredict;  // kill wrong-path D and E
    redirect.flush_e = mispredict;
    if (req.actual_taken) begin
      redirect.pc = req.actual_target;
    end else begin
      redirect.pc = seq_pc;
    end
  end

  // saturating update on a hit, weak allocation on a miss
  always_comb begin
    if (!tbl_hit) begin
      if (req.actual_taken) begin
        next_counter = bp_pkg::COUNTER_WEAK_T;
      end else begin
        next_counter = bp_pkg::COUNTER_WEAK_NT;
      end
    end else if (req.actual_taken) begin
      if (tbl_counter == bp_pkg::COUNTER_STRONG_T) begin
        next_counter = tbl_counter;
      end else begin
        next_counter = tbl_counter + 2'd1;
      end
    end else begin
      if (tbl_counter == bp_pkg::COUNTER_STRONG_NT) begin
        next_counter = tbl_counter;
      end else begin
        next_counter = tbl_counter - 2'd1;
      end
    end
  end

  always_comb begin
    table_wr.en      = req.valid;
    table_wr.pc      = req.pc;
    table_wr.counter = next_counter;
    // PCTargetE is computed whether or not the branch goes
    table_wr.target  = req.actual_target;
  end

  a_flush_pair: assert property (
    @(posedge clk) disable iff (!rst_n)
    redirect.flush_d == redirect.flush_e
  ) else $error("bp_resolve: flush_d and flush_e differ");

  // pipeline holds valid low through stalls and after reset
  a_flush_needs_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    (redirect.flush_d || redirect.flush_e) |-> req.valid
  ) else $error("bp_resolve: flush raised without a valid resolve at pc %h", req.pc);

endmodule

`default_nettype wire

/* src/bp_table.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_table #(
  parameter int INDEX_BITS = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  bp_pkg::pc_t       rd_a_pc,
  output logic              rd_a_hit,
  output bp_pkg::counter_t  rd_a_counter,
  output bp_pkg::pc_t       rd_a_target,
  input  bp_pkg::pc_t       rd_b_pc,
  output logic              rd_b_hit,
  output bp_pkg::counter_t  rd_b_counter,
  output bp_pkg::pc_t       rd_b_target,
  input  bp_pkg::table_wr_t wr
);

  localparam int ENTRIES  = 1 << INDEX_BITS;
  localparam int TAG_BITS = bp_pkg::PC_BITS - INDEX_BITS - 2;

  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [TAG_BITS-1:0]   tag_t;

  logic [ENTRIES-1:0] valid_q;
  tag_t               tag_q     [ENTRIES];
  bp_pkg::counter_t   counter_q [ENTRIES];
  bp_pkg::pc_t        target_q  [ENTRIES];

  index_t rd_a_idx;
  index_t rd_b_idx;
  index_t wr_idx;

  function automatic index_t index_of(input bp_pkg::pc_t pc);
    return pc[INDEX_BITS+1:2];  // word index, byte offset dropped
  endfunction

  function automatic tag_t tag_of(input bp_pkg::pc_t pc);
    return pc[bp_pkg::PC_BITS-1:INDEX_BITS+2];
  endfunction

  // port a, decode lookup
  assign rd_a_idx     = index_of(rd_a_pc);
  assign rd_a_hit     = valid_q[rd_a_idx] && (tag_q[rd_a_idx] == tag_of(rd_a_pc));
  assign rd_a_counter = counter_q[rd_a_idx];
  assign rd_a_target  = target_q[rd_a_idx];

  // port b, execute resolve
  assign rd_b_idx     = index_of(rd_b_pc);
  assign rd_b_hit     = valid_q[rd_b_idx] && (tag_q[rd_b_idx] == tag_of(rd_b_pc));
  assign rd_b_counter = counter_q[rd_b_idx];
  assign rd_b_target  = target_q[rd_b_idx];

  assign wr_idx = index_of(wr.pc);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;  // every lookup misses
    end else if (wr.en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // reads above see old contents in the write cycle
  always_ff @(posedge clk) begin
    if (wr.en) begin
      tag_q[wr_idx]     <= tag_of(wr.pc);
      counter_q[wr_idx] <= wr.counter;
      target_q[wr_idx]  <= wr.target;
    end
  end

  // target comes from the E-stage adder outside this block
  a_wr_target_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr.en |-> (wr.target[1:0] == 2'b00)
  ) else $error("bp_table: misaligned target %h for pc %h", wr.target, wr.pc);

endmodule

`default_nettype wire

/* src/branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predictor #(
  parameter int INDEX_BITS = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  bp_pkg::decode_req_t  decode_req,
  output bp_pkg::prediction_t  prediction,
  input  bp_pkg::resolve_req_t resolve_req,
  output bp_pkg::redirect_t    redirect
);

  // decode side
  bp_pkg::pc_t       lookup_pc;
  logic              lookup_hit;
  bp_pkg::counter_t  lookup_counter;
  bp_pkg::pc_t       lookup_target;

  // execute side
  bp_pkg::pc_t       resolve_pc;
  logic              resolve_hit;
  bp_pkg::counter_t  resolve_counter;
  bp_pkg::table_wr_t table_wr;

  bp_lookup #(
    .INDEX_BITS (INDEX_BITS)
  ) u_bp_lookup (
    .req         (decode_req),
    .tbl_pc      (lookup_pc),
    .tbl_hit     (lookup_hit),
    .tbl_counter (lookup_counter),
    .tbl_target  (lookup_target),
    .prediction  (prediction)
  );

  bp_table #(
    .INDEX_BITS (INDEX_BITS)
  ) u_bp_table (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_a_pc      (lookup_pc),
    .rd_a_hit     (lookup_hit),
    .rd_a_counter (lookup_counter),
    .rd_a_target  (lookup_target),
    .rd_b_pc      (resolve_pc),
    .rd_b_hit     (resolve_hit),
    .rd_b_counter (resolve_counter),
    .rd_b_target  (),  // resolver writes the E-stage target
    .wr           (table_wr)
  );

  bp_resolve #(
    .INDEX_BITS (INDEX_BITS)
  ) u_bp_resolve (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (resolve_req),
    .tbl_pc      (resolve_pc),
    .tbl_hit     (resolve_hit),
    .tbl_counter (resolve_counter),
    .redirect    (redirect),
    .table_wr    (table_wr)
  );

endmodule

`default_nettype wire
